// ==== axi_lite_wr_pkg.sv ====
////////////////////
// AXI4-Lite write slave definitions
// Bus widths, the write response code and the
// packed beat structs shared by every stage of
// the register slave.
////////////////////
`default_nettype none

package axi_lite_wr_pkg;

    localparam int ID_WIDTH   = 4;
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Only the two codes this slave can return
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
    } aw_beat_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } w_beat_t;

    // Decoded address beat, ready for the commit stage
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] index;
        logic                  error;
    } cmd_t;

    // Data beat with the strobes widened to one bit per data bit
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] mask;
    } wdata_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        axi_resp_e           resp;
    } b_beat_t;

endpackage

`default_nettype wire

// ==== axi_aw_channel.sv ====
////////////////////
// AW channel buffer
// Holds one write address beat and decodes it
// into a register index plus an error flag for
// misaligned or out of range addresses.
////////////////////
`default_nettype none

module axi_aw_channel
    import axi_lite_wr_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  aw_beat_t in_beat,
    output logic     out_valid,
    input  logic     out_ready,
    output cmd_t     out_cmd
);

    // Number of byte offset bits inside one data word
    localparam int ADDR_LSB = $clog2(STRB_WIDTH);

    logic ready_enable;
    cmd_t decoded;

    // Word index and error check, computed before the beat is stored
    always_comb begin
        decoded.id    = in_beat.id;
        decoded.index = in_beat.addr >> ADDR_LSB;
        decoded.error = (in_beat.addr[ADDR_LSB-1:0] != '0) ||
                        (decoded.index >= NUM_REGS);
    end

    // The buffer takes a new beat when empty or when its beat leaves now
    assign in_ready = ready_enable && (!out_valid || out_ready);

    always_ff @(posedge clock) begin
        if (!reset) begin
            ready_enable <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            // Ready comes up one cycle after reset is released
            ready_enable <= 1'b1;
            if (in_ready) begin
                out_valid <= in_valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            out_cmd <= decoded;
        end
    end

endmodule

`default_nettype wire

// ==== axi_w_channel.sv ====
////////////////////
// W channel buffer
// Holds one write data beat and widens its byte
// strobes into a per-bit write mask.
////////////////////
`default_nettype none

module axi_w_channel
    import axi_lite_wr_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    output logic    in_ready,
    input  w_beat_t in_beat,
    output logic    out_valid,
    input  logic    out_ready,
    output wdata_t  out_data
);

    logic   ready_enable;
    wdata_t expanded;

    // Each strobe bit covers one byte lane of the data word
    always_comb begin
        expanded.data = in_beat.data;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            expanded.mask[b*8 +: 8] = {8{in_beat.strb[b]}};
        end
    end

    assign in_ready = ready_enable && (!out_valid || out_ready);

    always_ff @(posedge clock) begin
        if (!reset) begin
            ready_enable <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            ready_enable <= 1'b1;
            // Stays full while the stored beat waits for the commit stage
            if (in_ready) begin
                out_valid <= in_valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            out_data <= expanded;
        end
    end

endmodule

`default_nettype wire

// ==== axi_write_commit.sv ====
////////////////////
// Write commit stage
// Joins one decoded address with one data beat,
// applies the masked write to the register bank
// and loads a write response for the B channel.
////////////////////
`default_nettype none

module axi_write_commit
    import axi_lite_wr_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic                               clock,
    input  logic                               reset,

    input  logic                               cmd_valid,
    input  cmd_t                               cmd,
    input  logic                               wd_valid,
    input  wdata_t                             wd,
    output logic                               beats_ready,

    output logic                               resp_valid,
    input  logic                               resp_ready,
    output b_beat_t                            resp,

    output logic [NUM_REGS-1:0][DATA_WIDTH-1:0] reg_bank
);

    logic resp_free;
    logic commit;

    // The response register can take a new entry if it is empty or draining
    assign resp_free = !resp_valid || resp_ready;

    // Both channel buffers are released together on a commit
    assign commit      = cmd_valid && wd_valid && resp_free;
    assign beats_ready = commit;

    always_ff @(posedge clock) begin
        if (!reset) begin
            reg_bank <= '0;
        end else if (commit && !cmd.error) begin
            // Masked bits take the new data, the rest keep their value
            for (int i = 0; i < NUM_REGS; i++) begin
                if (cmd.index == i) begin
                    reg_bank[i] <= (reg_bank[i] & ~wd.mask) | (wd.data & wd.mask);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            resp_valid <= 1'b0;
        end else if (resp_free) begin
            resp_valid <= commit;
        end
    end

    always_ff @(posedge clock) begin
        if (commit) begin
            resp.id   <= cmd.id;
            resp.resp <= cmd.error ? SLVERR : OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== axi_w_resp_skid_buffer.sv ====
////////////////////
// B channel skid buffer
// Keeps full throughput when the host stalls the
// write response. An accepted beat that cannot
// leave is parked in a skid register. The output
// is either registered or passed straight through.
////////////////////
`default_nettype none

module axi_w_resp_skid_buffer
    import axi_lite_wr_pkg::*;
#(
    parameter int REGISTER_OUTPUT = 1
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    output logic    in_ready,
    input  b_beat_t in_beat,
    output logic    out_valid,
    input  logic    out_ready,
    output b_beat_t out_beat
);

    logic    ready_enable;
    logic    skid_valid;
    b_beat_t skid_beat;
    logic    in_accept;
    logic    out_stalled;

    assign in_accept   = in_valid && in_ready;
    assign out_stalled = out_valid && !out_ready;

    // No new beat while one is parked, and none in the first cycle after reset
    assign in_ready = ready_enable && !skid_valid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            ready_enable <= 1'b0;
            skid_valid   <= 1'b0;
        end else begin
            ready_enable <= 1'b1;
            if (in_accept && out_stalled) begin
                skid_valid <= 1'b1;
            end else if (!out_stalled) begin
                skid_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_accept && out_stalled) begin
            skid_beat <= in_beat;
        end
    end

    generate
        if (REGISTER_OUTPUT != 0) begin : g_registered
            always_ff @(posedge clock) begin
                if (!reset) begin
                    out_valid <= 1'b0;
                end else if (!out_stalled) begin
                    out_valid <= skid_valid || in_accept;
                end
            end

            // The parked beat is older, so it leaves first
            always_ff @(posedge clock) begin
                if (!out_stalled) begin
                    out_beat <= skid_valid ? skid_beat : in_beat;
                end
            end
        end else begin : g_passthrough
            // Output follows the input in the same cycle
            assign out_valid = skid_valid || in_valid;
            assign out_beat  = skid_valid ? skid_beat : in_beat;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== axi_lite_reg_slave.sv ====
////////////////////
// AXI4-Lite register slave, write only
// Address and data buffers feed a commit stage
// that updates the control register bank. Write
// responses leave through a skid buffer.
////////////////////
`default_nettype none

module axi_lite_reg_slave
    import axi_lite_wr_pkg::*;
#(
    parameter int NUM_REGS        = 8,
    parameter int REGISTER_OUTPUT = 1
) (
    input  logic                               clock,
    input  logic                               reset,

    input  logic                               aw_valid,
    output logic                               aw_ready,
    input  aw_beat_t                           aw_beat,

    input  logic                               w_valid,
    output logic                               w_ready,
    input  w_beat_t                            w_beat,

    output logic                               b_valid,
    input  logic                               b_ready,
    output b_beat_t                            b_beat,

    output logic [NUM_REGS-1:0][DATA_WIDTH-1:0] reg_bank
);

    logic    cmd_valid;
    cmd_t    cmd;
    logic    wd_valid;
    wdata_t  wd;
    // Releases the address and the data buffer on the same edge
    logic    beats_ready;
    logic    resp_valid;
    logic    resp_ready;
    b_beat_t resp;

    axi_aw_channel #(
        .NUM_REGS (NUM_REGS)
    ) u_aw_channel (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (aw_valid),
        .in_ready  (aw_ready),
        .in_beat   (aw_beat),
        .out_valid (cmd_valid),
        .out_ready (beats_ready),
        .out_cmd   (cmd)
    );

    axi_w_channel u_w_channel (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (w_valid),
        .in_ready  (w_ready),
        .in_beat   (w_beat),
        .out_valid (wd_valid),
        .out_ready (beats_ready),
        .out_data  (wd)
    );

    axi_write_commit #(
        .NUM_REGS (NUM_REGS)
    ) u_write_commit (
        .clock       (clock),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .wd_valid    (wd_valid),
        .wd          (wd),
        .beats_ready (beats_ready),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp        (resp),
        .reg_bank    (reg_bank)
    );

    axi_w_resp_skid_buffer #(
        .REGISTER_OUTPUT (REGISTER_OUTPUT)
    ) u_resp_skid_buffer (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (resp_valid),
        .in_ready  (resp_ready),
        .in_beat   (resp),
        .out_valid (b_valid),
        .out_ready (b_ready),
        .out_beat  (b_beat)
    );

endmodule

`default_nettype wire

// ==== tb_axi_lite_tasks.svh ====
////////////////////
// Testbench tasks for the AXI4-Lite write slave
// Channel drivers, response and register checks,
// and one task per tested behavior.
////////////////////
`ifndef TB_AXI_LITE_TASKS_SVH
`define TB_AXI_LITE_TASKS_SVH

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
endtask

task automatic check_value(input string what, input logic [63:0] got,
                           input logic [63:0] expected);
    if (got !== expected) begin
        report_failure($sformatf("Fail at %0d ns: %s expected 0x%0h got 0x%0h",
                                 $time, what, expected, got));
    end
endtask

task automatic check_bank(input string when);
    for (int i = 0; i < NUM_REGS; i++) begin
        check_value($sformatf("reg_bank[%0d] %s", i, when), reg_bank[i], model_regs[i]);
    end
endtask

// Moves on by whole cycles and lands on the drive point again
task automatic wait_cycles(input int n);
    repeat (n) begin
        @(posedge clock);
        #DRIVE_DELAY;
    end
endtask

task automatic send_aw(input logic [ADDR_WIDTH-1:0] addr, input logic [ID_WIDTH-1:0] id,
                       output time accept_t);
    aw_valid     = 1'b1;
    aw_beat.id   = id;
    aw_beat.addr = addr;
    @(posedge clock);
    while (!aw_ready) @(posedge clock);
    accept_t = $time;
    #DRIVE_DELAY;
    aw_valid = 1'b0;
endtask

task automatic send_w(input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb,
                      output time accept_t);
    w_valid     = 1'b1;
    w_beat.data = data;
    w_beat.strb = strb;
    @(posedge clock);
    while (!w_ready) @(posedge clock);
    accept_t = $time;
    #DRIVE_DELAY;
    w_valid = 1'b0;
endtask

task automatic expect_b(input b_beat_t expected, output time seen_t);
    @(posedge clock);
    while (!(b_valid && b_ready)) @(posedge clock);
    seen_t = $time;
    check_value("B response ID", b_beat.id, expected.id);
    check_value("B response code", b_beat.resp, expected.resp);
    #DRIVE_DELAY;
endtask

// One write on an idle slave with b_ready held high
task automatic directed_write(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data,
                              input logic [STRB_WIDTH-1:0] strb,
                              input logic [ID_WIDTH-1:0] id,
                              input int aw_delay, input int w_delay);
    b_beat_t expected;
    time     t_aw;
    time     t_w;
    time     t_late;
    time     t_b;
    expected = model_write(addr, data, strb, id);
    fork
        begin
            wait_cycles(aw_delay);
            send_aw(addr, id, t_aw);
        end
        begin
            wait_cycles(w_delay);
            send_w(data, strb, t_w);
        end
    join
    t_late = (t_aw > t_w) ? t_aw : t_w;
    repeat (2) @(posedge clock);
    check_bank($sformatf("two cycles after the write to 0x%0h", addr));
    #DRIVE_DELAY;
    expect_b(expected, t_b);
    check_value("B latency in cycles", (t_b - t_late) / CLK_PERIOD, B_LATENCY);
endtask

task automatic test_full_writes();
    for (int i = 0; i < NUM_REGS; i++) begin
        directed_write(ADDR_WIDTH'(i * STRB_WIDTH), 32'hc0de_0000 + 32'(i * 16'h1111),
                       4'hf, ID_WIDTH'(i), 0, 0);
    end
endtask

task automatic test_partial_strobes();
    directed_write(16'h000c, 32'hdead_beef, 4'b0001, 4'h3, 0, 0);
    directed_write(16'h000c, 32'h1234_5678, 4'b1010, 4'h4, 0, 0);
    directed_write(16'h0014, 32'h0f0f_0f0f, 4'b0101, 4'h5, 0, 0);
    // No strobe at all still answers OKAY and keeps the register
    directed_write(16'h0014, 32'hffff_ffff, 4'b0000, 4'h6, 0, 0);
endtask

task automatic test_error_addresses();
    directed_write(16'h0009, 32'haaaa_aaaa, 4'hf, 4'h9, 0, 0);
    directed_write(16'h0012, 32'hbbbb_bbbb, 4'hf, 4'ha, 0, 0);
    directed_write(ADDR_WIDTH'(NUM_REGS * STRB_WIDTH), 32'hcccc_cccc, 4'hf, 4'hb, 0, 0);
    directed_write(16'hfffc, 32'hdddd_dddd, 4'hf, 4'hc, 0, 0);
endtask

task automatic test_channel_order();
    directed_write(16'h0004, 32'h0bad_cafe, 4'hf, 4'hd, 0, 4);
    directed_write(16'h0018, 32'h600d_f00d, 4'hf, 4'he, 5, 0);
    directed_write(16'h001c, 32'h7777_1111, 4'b0110, 4'hf, 0, 0);
endtask

task automatic test_random_stream();
    logic [ADDR_WIDTH-1:0] addrs [STREAM_LEN];
    logic [DATA_WIDTH-1:0] datas [STREAM_LEN];
    logic [STRB_WIDTH-1:0] strbs [STREAM_LEN];
    logic [ID_WIDTH-1:0]   ids [STREAM_LEN];
    int                    w_gaps [STREAM_LEN];
    logic [31:0]           r;
    logic [31:0]           toggle;
    int                    received;
    b_beat_t               expected;
    time                   t_aw;
    time                   t_w;
    received = 0;
    // All stimulus is drawn up front so only the b_ready process uses the seed later
    for (int n = 0; n < STREAM_LEN; n++) begin
        r        = $random(seed);
        addrs[n] = ADDR_WIDTH'((r[3:0] % (NUM_REGS + 2)) * STRB_WIDTH);
        if (r[6:4] == 3'd0) begin
            addrs[n][1:0] = r[8:7];
        end
        strbs[n]  = r[12:9];
        ids[n]    = r[16:13];
        w_gaps[n] = r[18:17];
        datas[n]  = $random(seed);
    end
    fork
        begin
            for (int n = 0; n < STREAM_LEN; n++) begin
                exp_q.push_back(model_write(addrs[n], datas[n], strbs[n], ids[n]));
                fork
                    send_aw(addrs[n], ids[n], t_aw);
                    begin
                        wait_cycles(w_gaps[n]);
                        send_w(datas[n], strbs[n], t_w);
                    end
                join
            end
        end
        begin
            while (received < STREAM_LEN) begin
                toggle  = $random(seed);
                b_ready = (toggle[1:0] != 2'b00);
                wait_cycles(1);
            end
        end
        begin
            while (received < STREAM_LEN) begin
                @(posedge clock);
                if (b_valid && b_ready) begin
                    if (exp_q.size() == 0) begin
                        report_failure("A write response arrived with no write outstanding");
                    end else begin
                        expected = exp_q.pop_front();
                        check_value($sformatf("stream response %0d ID", received),
                                    b_beat.id, expected.id);
                        check_value($sformatf("stream response %0d code", received),
                                    b_beat.resp, expected.resp);
                        received++;
                    end
                end
            end
        end
    join
    b_ready = 1'b1;
    repeat (10) begin
        @(posedge clock);
        if (b_valid) begin
            report_failure("An extra write response appeared after the random stream");
        end
    end
    #DRIVE_DELAY;
    check_bank("after the random stream");
endtask

`endif

// ==== tb_axi_lite_reg_slave.sv ====
////////////////////
// Testbench for the AXI4-Lite write slave
// Drives the AW and W channels and checks write
// responses and the register bank against a
// reference model of the register rules.
////////////////////
`default_nettype none

module tb_axi_lite_reg_slave
    import axi_lite_wr_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REGS        = 8;
    localparam int REGISTER_OUTPUT = 1;
    localparam int CLK_PERIOD      = 8;
    localparam int DRIVE_DELAY     = 1;
    localparam int RESET_CYCLES    = 10;
    localparam int STREAM_LEN      = 40;
    localparam int B_LATENCY       = 3;
    // Directed writes of the four directed tests plus the random stream
    localparam int TOTAL_TXNS      = NUM_REGS + 4 + 4 + 3 + STREAM_LEN;
    localparam int TIMEOUT_NS      = CLK_PERIOD * 40 * TOTAL_TXNS + CLK_PERIOD * 200;

    logic                                clock;
    logic                                reset;
    logic                                aw_valid;
    logic                                aw_ready;
    aw_beat_t                            aw_beat;
    logic                                w_valid;
    logic                                w_ready;
    w_beat_t                             w_beat;
    logic                                b_valid;
    logic                                b_ready;
    b_beat_t                             b_beat;
    logic [NUM_REGS-1:0][DATA_WIDTH-1:0] reg_bank;

    // Reference model state
    logic [DATA_WIDTH-1:0] model_regs [NUM_REGS];
    b_beat_t               exp_q [$];
    integer                seed = 32'h0f3a_d2ab;

    axi_lite_reg_slave #(
        .NUM_REGS        (NUM_REGS),
        .REGISTER_OUTPUT (REGISTER_OUTPUT)
    ) u_dut (
        .clock    (clock),
        .reset    (reset),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_beat  (aw_beat),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_beat   (w_beat),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_beat   (b_beat),
        .reg_bank (reg_bank)
    );

    // A word aligned address below the bank gets OKAY and takes the strobed bytes.
    // Anything else gets SLVERR and leaves the registers alone
    function automatic b_beat_t model_write(
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [DATA_WIDTH-1:0] data,
        input logic [STRB_WIDTH-1:0] strb,
        input logic [ID_WIDTH-1:0]   id
    );
        int      index;
        b_beat_t result;
        index     = addr / STRB_WIDTH;
        result.id = id;
        if ((addr % STRB_WIDTH) != 0 || index >= NUM_REGS) begin
            result.resp = SLVERR;
        end else begin
            result.resp = OKAY;
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    model_regs[index][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        return result;
    endfunction

    `include "tb_axi_lite_tasks.svh"

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(TIMEOUT_NS);
        report_failure($sformatf("Timeout: the run did not finish within %0d ns", TIMEOUT_NS));
    end

    initial begin
        reset    = 1'b0;
        aw_valid = 1'b0;
        aw_beat  = '0;
        w_valid  = 1'b0;
        w_beat   = '0;
        b_ready  = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        check_value("aw_ready in reset", aw_ready, 0);
        check_value("w_ready in reset", w_ready, 0);
        check_value("b_valid in reset", b_valid, 0);
        check_bank("in reset");
        #DRIVE_DELAY;
        reset = 1'b1;
        // Ready stays low for the first cycle after release
        @(posedge clock);
        check_value("aw_ready one cycle after reset", aw_ready, 0);
        check_value("w_ready one cycle after reset", w_ready, 0);
        #DRIVE_DELAY;
        test_full_writes();
        test_partial_strobes();
        test_error_addresses();
        test_channel_order();
        test_random_stream();
        check_bank("at the end of the run");
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
axi_lite_wr_pkg.sv
axi_aw_channel.sv
axi_w_channel.sv
axi_write_commit.sv
axi_w_resp_skid_buffer.sv
axi_lite_reg_slave.sv
tb_axi_lite_reg_slave.sv
